//--- rtl/wavegen_fmt_pkg.sv
`default_nettype none

package wavegen_fmt_pkg;

	// Samples and the scaled output are Q4.12 words.
	localparam int DATA_WIDTH = 16;
	localparam int FRAC_BITS  = 12;

	// The amplitude input is a small signed integer.
	localparam int INT_BITS = 4;

	// One period spans 32 phase steps.
	localparam int LUT_ADDR  = 5;
	localparam int LUT_DEPTH = 32;

	// Cosine leads sine by a quarter period, i.e. 8 entries.
	localparam int QUARTER = 8;

	typedef logic signed [DATA_WIDTH-1:0] sample_t;
	typedef logic signed [INT_BITS-1:0]   amp_t;
	typedef logic        [LUT_ADDR-1:0]   addr_t;

	// Plus one in Q4.12, and one eighth of that for the triangle slope.
	localparam sample_t FULL_SCALE = 16'sh1000;
	localparam sample_t TRI_STEP   = 16'sh0200;
	localparam sample_t RESET_AMP  = 16'sh1000;

	// Sine samples in hexadecimal, one per line.
	localparam string SINE_FILE = "rtl/sine_table.mem";

endpackage

`default_nettype wire

//--- rtl/wavegen_ctrl_pkg.sv
`default_nettype none

package wavegen_ctrl_pkg;

	// Sequencer states. Encoding 2'b11 is unused and falls back to IDLE.
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		CONFIG = 2'd1,
		GEN    = 2'd2
	} gen_state_t;

	// Waveform selector, in the encoding order of the sel_i input.
	typedef enum logic [1:0] {
		SINE     = 2'd0,
		COSINE   = 2'd1,
		TRIANGLE = 2'd2,
		SQUARE   = 2'd3
	} wave_sel_t;

	// Control levels decoded from the sequencer state.
	typedef struct packed {
		logic load_amp;
		logic gen_run;
	} gen_ctrl_t;

	// One waveform sample, marked by its valid bit.
	typedef struct packed {
		logic                     valid;
		wavegen_fmt_pkg::sample_t value;
	} wave_sample_t;

endpackage

`default_nettype wire

//--- rtl/wavegen_sequencer.sv
`default_nettype none

module wavegen_sequencer (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        en_low_i,
	input  wire logic                        enh_conf_i,
	output wavegen_ctrl_pkg::gen_ctrl_t      ctrl_o
);

	import wavegen_ctrl_pkg::*;

	gen_state_t state_q;
	gen_state_t state_d;

	// The state register. A new state takes effect one edge after the
	// inputs that select it.
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Next-state logic.
	// The configure request has priority in every state.
	// With both inputs low the sequencer heads for GEN.
	// With only en_low_i high it drops back to IDLE.
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (enh_conf_i) begin
					state_d = CONFIG;
				end else if (!en_low_i) begin
					state_d = GEN;
				end
			end
			CONFIG: begin
				if (!enh_conf_i) begin
					state_d = en_low_i ? IDLE : GEN;
				end
			end
			GEN: begin
				if (enh_conf_i) begin
					state_d = CONFIG;
				end else if (en_low_i) begin
					state_d = IDLE;
				end
			end
			default: begin
				// The unused encoding recovers to IDLE.
				state_d = IDLE;
			end
		endcase
	end

	// Control levels are a plain decode of the current state.
	// They can therefore never be high together.
	assign ctrl_o.load_amp = (state_q == CONFIG);
	assign ctrl_o.gen_run  = (state_q == GEN);

endmodule

`default_nettype wire

//--- rtl/waveform_source.sv
`default_nettype none

module waveform_source (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wavegen_ctrl_pkg::gen_ctrl_t      ctrl_i,
	input  wavegen_ctrl_pkg::wave_sel_t      sel_i,
	output wavegen_ctrl_pkg::wave_sample_t   sample_o
);

	import wavegen_fmt_pkg::*;
	import wavegen_ctrl_pkg::*;

	// Sine table with two read ports, one for sine and one for cosine.
	sample_t sine_rom [LUT_DEPTH];

	addr_t   addr_q;
	addr_t   cos_addr;
	sample_t sin_val;
	sample_t cos_val;
	sample_t tri_ramp;
	sample_t tri_val;
	sample_t squ_val;
	sample_t sel_val;
	logic    valid_q;
	sample_t value_q;

	// The table contents come from the hex file at elaboration.
	initial begin
		$readmemh(SINE_FILE, sine_rom);
	end

	// Phase address counter.
	// It sits at zero outside GEN, so every run starts at index zero.
	// In GEN it steps once per cycle and wraps naturally at 32.
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q <= '0;
		end else if (!ctrl_i.gen_run) begin
			addr_q <= '0;
		end else begin
			addr_q <= addr_q + addr_t'(1);
		end
	end

	// Cosine is the same table read a quarter period ahead.
	// The 5-bit sum wraps modulo 32 by itself.
	assign cos_addr = addr_q + addr_t'(QUARTER);
	assign sin_val  = sine_rom[addr_q];
	assign cos_val  = sine_rom[cos_addr];

	// Triangle. The low four address bits give the position within a half
	// period, the top bit tells rising from falling.
	// Rising half goes from minus full scale upward.
	// Falling half goes from plus full scale downward.
	assign tri_ramp = sample_t'(addr_q[LUT_ADDR-2:0]) * TRI_STEP;
	assign tri_val  = addr_q[LUT_ADDR-1] ? (FULL_SCALE - tri_ramp)
	                                     : (tri_ramp - FULL_SCALE);

	// Square is high for the first half period, low for the second.
	assign squ_val = addr_q[LUT_ADDR-1] ? -FULL_SCALE : FULL_SCALE;

	// Waveform select.
	always_comb begin
		case (sel_i)
			SINE:     sel_val = sin_val;
			COSINE:   sel_val = cos_val;
			TRIANGLE: sel_val = tri_val;
			SQUARE:   sel_val = squ_val;
			default:  sel_val = sin_val;
		endcase
	end

	// The valid bit follows gen_run with one cycle of delay.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= ctrl_i.gen_run;
		end
	end

	// The sample value only moves while generating.
	// Downstream looks at it only when valid is set.
	always_ff @(posedge clk) begin
		if (ctrl_i.gen_run) begin
			value_q <= sel_val;
		end
	end

	assign sample_o.valid = valid_q;
	assign sample_o.value = value_q;

endmodule

`default_nettype wire

//--- rtl/amplitude_scaler.sv
`default_nettype none

module amplitude_scaler (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wavegen_ctrl_pkg::gen_ctrl_t      ctrl_i,
	input  wavegen_fmt_pkg::amp_t            amp_i,
	input  wavegen_ctrl_pkg::wave_sample_t   sample_i,
	output wavegen_fmt_pkg::sample_t         data_o,
	output logic                             wr_en_o
);

	import wavegen_fmt_pkg::*;
	import wavegen_ctrl_pkg::*;

	sample_t                      amp_q;
	logic signed [2*DATA_WIDTH-1:0] product;
	sample_t                      data_q;
	logic                         wr_en_q;

	// Amplitude register, in Q4.12.
	// The integer input lands in the top INT_BITS, the fraction is zero.
	// It is reloaded on every CONFIG cycle, so the last one wins.
	always_ff @(posedge clk) begin
		if (rst) begin
			amp_q <= RESET_AMP;
		end else if (ctrl_i.load_amp) begin
			amp_q <= sample_t'({amp_i, {FRAC_BITS{1'b0}}});
		end
	end

	// Signed Q4.12 times Q4.12 gives a Q8.24 product.
	// A negative amplitude flips the wave.
	assign product = $signed(sample_i.value) * $signed(amp_q);

	// Output register.
	// Taking the bits from FRAC_BITS upward brings the product back to Q4.12.
	// Anything above the top bit is dropped, so overflow wraps.
	// The data only changes for a valid sample.
	always_ff @(posedge clk) begin
		if (rst) begin
			data_q  <= '0;
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= sample_i.valid;
			if (sample_i.valid) begin
				data_q <= product[FRAC_BITS +: DATA_WIDTH];
			end
		end
	end

	assign data_o  = data_q;
	assign wr_en_o = wr_en_q;

endmodule

`default_nettype wire

//--- rtl/funct_generator.sv
`default_nettype none

module funct_generator (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        en_low_i,
	input  wire logic                        enh_conf_i,
	input  wavegen_fmt_pkg::amp_t            amp_i,
	input  wavegen_ctrl_pkg::wave_sel_t      sel_i,
	output wavegen_fmt_pkg::sample_t         data_o,
	output logic                             wr_en_o
);

	import wavegen_ctrl_pkg::*;

	// Control levels from the sequencer, shared by source and scaler.
	gen_ctrl_t    ctrl;

	// Registered sample from the source into the scaler.
	wave_sample_t sample;

	// State machine for idle, configure and generate.
	wavegen_sequencer u_sequencer (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low_i),
		.enh_conf_i (enh_conf_i),
		.ctrl_o     (ctrl)
	);

	// Phase counter and waveform synthesis, one cycle of latency.
	waveform_source u_source (
		.clk      (clk),
		.rst      (rst),
		.ctrl_i   (ctrl),
		.sel_i    (sel_i),
		.sample_o (sample)
	);

	// Amplitude scaling and output strobe, one more cycle.
	amplitude_scaler u_scaler (
		.clk      (clk),
		.rst      (rst),
		.ctrl_i   (ctrl),
		.amp_i    (amp_i),
		.sample_i (sample),
		.data_o   (data_o),
		.wr_en_o  (wr_en_o)
	);

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_o
);

	localparam int HALF_PERIOD  = 2;
	localparam int RESET_CYCLES = 2;

	// Free running clock with a period of four time units.
	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// Reset covers two rising edges and drops just after the second one.
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

//--- verification/wavegen_sequencer_assert.sv
`default_nettype none

module wavegen_sequencer_assert (
	input wire logic                   clk,
	input wire logic                   rst,
	input wire logic                   en_low_i,
	input wire logic                   enh_conf_i,
	input wavegen_ctrl_pkg::gen_ctrl_t ctrl_i
);

	// The two control levels come from different states.
	never_both: assert property (@(posedge clk) disable iff (rst)
		!(ctrl_i.load_amp && ctrl_i.gen_run))
		else $error("load_amp and gen_run are high in the same cycle");

	// On the first cycle out of reset the sequencer sits in IDLE.
	idle_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> (!ctrl_i.load_amp && !ctrl_i.gen_run))
		else $error("control levels are not low on the first cycle after reset");

	// A configure request during GEN moves to CONFIG at the next edge.
	gen_to_config: assert property (@(posedge clk) disable iff (rst)
		(ctrl_i.gen_run && enh_conf_i) |=> ctrl_i.load_amp)
		else $error("configure request during GEN did not raise load_amp");

	// CONFIG with both inputs low starts generating.
	config_to_gen: assert property (@(posedge clk) disable iff (rst)
		(ctrl_i.load_amp && !enh_conf_i && !en_low_i) |=> ctrl_i.gen_run)
		else $error("CONFIG with both inputs low did not raise gen_run");

endmodule

bind wavegen_sequencer wavegen_sequencer_assert u_sequencer_assert (
	.clk        (clk),
	.rst        (rst),
	.en_low_i   (en_low_i),
	.enh_conf_i (enh_conf_i),
	.ctrl_i     (ctrl_o)
);

`default_nettype wire

//--- verification/funct_generator_tb.sv
`default_nettype none

module funct_generator_tb;

	import wavegen_fmt_pkg::*;
	import wavegen_ctrl_pkg::*;

	// One stimulus row. The sequencer passes through the via state, then
	// stays in GEN for gen_cycles cycles.
	typedef struct packed {
		gen_state_t via;
		amp_t       amp;
		wave_sel_t  sel;
		logic [7:0] gen_cycles;
	} phase_t;

	localparam int NUM_PHASES   = 8;
	localparam int VIA_CYCLES   = 3;
	localparam int RESET_CYCLES = 2;
	localparam int SLACK_CYCLES = 50;

	// Rows 0 and 1 go from IDLE straight to GEN, so their amplitudes are never loaded.
	// The 40 cycle sine run wraps the index past 31.
	// The triangle run stops mid period, so the run after IDLE must restart at zero.
	// Row 4 keeps the negative amplitude through IDLE.
	// Rows 5 and 6 enter CONFIG directly from GEN.
	localparam phase_t PHASES [NUM_PHASES] = '{
		'{IDLE,   4'sd5,  SINE,     8'd0},
		'{IDLE,   4'sd5,  SINE,     8'd40},
		'{CONFIG, 4'sd3,  COSINE,   8'd20},
		'{CONFIG, -4'sd2, TRIANGLE, 8'd36},
		'{IDLE,   4'sd7,  SQUARE,   8'd32},
		'{CONFIG, 4'sd3,  SQUARE,   8'd16},
		'{CONFIG, -4'sd2, COSINE,   8'd12},
		'{IDLE,   4'sd0,  SINE,     8'd0}
	};

	logic       clk;
	logic       rst;
	logic       en_low_i;
	logic       enh_conf_i;
	amp_t       amp_i;
	wave_sel_t  sel_i;
	sample_t    data_o;
	logic       wr_en_o;

	sample_t    sine_model [LUT_DEPTH];
	sample_t    model_amp;
	sample_t    exp_q [$];
	sample_t    exp_val;
	logic [2:0] gen_req_pipe;
	int         value_errors = 0;
	int         strobe_errors = 0;
	int         cycle_count = 0;
	int         cycle_limit;

	tb_clock_gen u_clock_gen (
		.clk_o (clk),
		.rst_o (rst)
	);

	funct_generator DUT (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low_i),
		.enh_conf_i (enh_conf_i),
		.amp_i      (amp_i),
		.sel_i      (sel_i),
		.data_o     (data_o),
		.wr_en_o    (wr_en_o)
	);

	// Reference sample for one index of a run, scaled and wrapped to 16 bits.
	function automatic sample_t expected_sample(input wave_sel_t sel, input int idx,
		input sample_t amp);
		sample_t wave;
		int      product;
		wave = '0;
		case (sel)
			SINE:     wave = sine_model[addr_t'(idx)];
			COSINE:   wave = sine_model[addr_t'((idx + QUARTER) % LUT_DEPTH)];
			TRIANGLE: begin
				if (idx < LUT_DEPTH / 2) begin
					wave = sample_t'(idx * int'(TRI_STEP) - int'(FULL_SCALE));
				end else begin
					wave = sample_t'(int'(FULL_SCALE) - (idx - LUT_DEPTH / 2) * int'(TRI_STEP));
				end
			end
			SQUARE:   wave = (idx < LUT_DEPTH / 2) ? FULL_SCALE : -FULL_SCALE;
		endcase
		product = int'(wave) * int'(amp);
		return sample_t'(product >>> FRAC_BITS);
	endfunction

	// Length of the whole stimulus table in clock cycles.
	function automatic int total_cycles();
		int sum;
		sum = RESET_CYCLES;
		for (int r = 0; r < NUM_PHASES; r++) begin
			sum += VIA_CYCLES + int'(PHASES[r].gen_cycles);
		end
		return sum;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// Drive one row and queue the samples its GEN run should produce.
	// The selector only changes at the start of GEN, so the last sample of
	// the previous run still sees its own selector.
	task automatic apply_phase(input phase_t ph);
		int idx;
		en_low_i   = (ph.via == IDLE);
		enh_conf_i = (ph.via == CONFIG);
		amp_i      = ph.amp;
		if (ph.via == CONFIG) begin
			model_amp = sample_t'(int'(ph.amp) * (1 << FRAC_BITS));
		end
		wait_cycles(VIA_CYCLES);
		if (ph.gen_cycles != 0) begin
			en_low_i   = 1'b0;
			enh_conf_i = 1'b0;
			sel_i      = ph.sel;
			for (idx = 0; idx < int'(ph.gen_cycles); idx++) begin
				exp_q.push_back(expected_sample(ph.sel, idx % LUT_DEPTH, model_amp));
			end
			wait_cycles(int'(ph.gen_cycles));
		end
	endtask

	// Both inputs low select GEN from any state.
	// A strobe follows two edges after each edge that takes such a request.
	always @(posedge clk) begin
		if (rst) begin
			gen_req_pipe <= '0;
		end else begin
			gen_req_pipe <= {gen_req_pipe[1:0], !en_low_i && !enh_conf_i};
		end
	end

	// Outputs are checked at the falling edge, halfway between updates.
	always @(negedge clk) begin
		if (!rst) begin
			if (gen_req_pipe[2]) begin
				exp_val = exp_q.pop_front();
				assert (wr_en_o === 1'b1) else begin
					strobe_errors++;
					$display("Missing write strobe at time %0t during a GEN run.", $time);
				end
				assert (wr_en_o !== 1'b1 || data_o === exp_val) else begin
					value_errors++;
					$display("ERROR at time %0t: data_o expected %h, observed %h",
						$time, exp_val, data_o);
				end
			end else begin
				assert (wr_en_o === 1'b0) else begin
					strobe_errors++;
					$display("Unexpected write strobe at time %0t outside a GEN run.", $time);
				end
			end
		end
	end

	// Watchdog on the cycle count.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the stimulus never completed.", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		en_low_i    = 1'b1;
		enh_conf_i  = 1'b0;
		amp_i       = '0;
		sel_i       = SINE;
		model_amp   = RESET_AMP;
		cycle_limit = total_cycles() + SLACK_CYCLES;
		$readmemh(SINE_FILE, sine_model);

		// Reset drops one time unit after an edge, in step with the stimulus.
		@(negedge rst);
		for (int r = 0; r < NUM_PHASES; r++) begin
			apply_phase(PHASES[r]);
		end

		// Let the tail of the last run drain out of the pipeline.
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(negedge clk);
		#1;

		$display("Value errors: %0d, strobe errors: %0d", value_errors, strobe_errors);
		if (value_errors == 0 && strobe_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/sine_table.mem
// One column of 16-bit Q4.12 sine samples in hex, entry 0 of the period first.
0000
031F
061F
08E4
0B50
0D4E
0EC8
0FB1
1000
0FB1
0EC8
0D4E
0B50
08E4
061F
031F
0000
FCE1
F9E1
F71C
F4B0
F2B2
F138
F04F
F000
F04F
F138
F2B2
F4B0
F71C
F9E1
FCE1

//--- sim.f
rtl/wavegen_fmt_pkg.sv
rtl/wavegen_ctrl_pkg.sv
rtl/wavegen_sequencer.sv
rtl/waveform_source.sv
rtl/amplitude_scaler.sv
rtl/funct_generator.sv
verification/tb_clock_gen.sv
verification/wavegen_sequencer_assert.sv
verification/funct_generator_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the function generator testbench with Verilator.
# The table file is read relative to the project root, so run from there.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module funct_generator_tb -o sim_funct_generator
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

output=$(./obj_dir/sim_funct_generator)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
exit 1
